//--- hdl/board_io_pkg.sv
// Shared widths, sideband structs and reset sequencer states, imported by every board I/O block
package board_io_pkg;

    // Two QSFP-DD cages on the board
    localparam int CAGE_COUNT = 2;

    // Two push buttons and two DIP switches
    localparam int SWITCH_COUNT = 4;

    // Bits 3:2 are the buttons, bits 1:0 the switches
    typedef logic [SWITCH_COUNT-1:0] switch_vec_t;

    // Wide enough for a 250000 sample divider and for hold counts
    typedef logic [19:0] tick_cnt_t;

    // Raw cage pins, all idle high
    typedef struct packed {
        logic interrupt_n;
        logic mod_prs_n;
        logic scl;
        logic sda;
    } cage_in_t;

    // I2C drive from the core
    // A set _t bit releases the line to its pull-up
    typedef struct packed {
        logic scl_o;
        logic scl_t;
        logic sda_o;
        logic sda_t;
    } cage_drive_t;

    // Reset release sequence
    typedef enum logic [1:0] {
        RST_HOLD_IN,
        RST_STRETCH,
        RST_RUN
    } rst_state_t;

endpackage

//--- hdl/sample_timer.sv
// Slow sample tick generator, one pulse every SAMPLE_DIV clocks for the reset and debounce logic
module sample_timer #(
    parameter int SAMPLE_DIV = 4
) (
    input  logic pcie_clk,
    input  logic rst_i,
    output logic sample_tick_o
);
    import board_io_pkg::*;

    localparam tick_cnt_t RELOAD = tick_cnt_t'(SAMPLE_DIV - 1);

    tick_cnt_t div_cnt_q;

    // Down counter, tick fires on the reload cycle
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            div_cnt_q     <= RELOAD;
            sample_tick_o <= 1'b0;
        end else if (div_cnt_q == '0) begin
            div_cnt_q     <= RELOAD;
            sample_tick_o <= 1'b1;
        end else begin
            div_cnt_q     <= div_cnt_q - 1'b1;
            sample_tick_o <= 1'b0;
        end
    end

    // With any real division the tick is a single-cycle pulse
    a_tick_single: assert property (
        @(posedge pcie_clk) disable iff (rst_i)
        (SAMPLE_DIV > 1) && sample_tick_o |=> !sample_tick_o
    ) else $error("sample tick high on consecutive cycles");

endmodule

//--- hdl/rst_release_seq.sv
// Reset stretcher that holds the core reset for HOLD_TICKS sample ticks after the system reset
module rst_release_seq #(
    parameter int HOLD_TICKS = 20
) (
    input  logic pcie_clk,
    input  logic rst_i,
    input  logic sample_tick_i,
    output logic core_rst_o
);
    import board_io_pkg::*;

    localparam tick_cnt_t HOLD_COUNT = tick_cnt_t'(HOLD_TICKS);

    rst_state_t state_q;
    rst_state_t state_d;
    tick_cnt_t  tick_cnt_q;
    tick_cnt_t  tick_cnt_d;

    always_comb begin
        state_d    = state_q;
        tick_cnt_d = tick_cnt_q;
        case (state_q)
            RST_HOLD_IN: begin
                // System reset has just ended
                state_d    = RST_STRETCH;
                tick_cnt_d = '0;
            end
            RST_STRETCH: begin
                if (sample_tick_i) begin
                    tick_cnt_d = tick_cnt_q + 1'b1;
                    if (tick_cnt_d == HOLD_COUNT) begin
                        state_d = RST_RUN;
                    end
                end
            end
            default: begin
                // Stay released until the next system reset
                state_d = RST_RUN;
            end
        endcase
    end

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            state_q    <= RST_HOLD_IN;
            tick_cnt_q <= '0;
            core_rst_o <= 1'b1;
        end else begin
            state_q    <= state_d;
            tick_cnt_q <= tick_cnt_d;
            core_rst_o <= (state_d != RST_RUN);
        end
    end

    // Core must never run while the system reset is asserted
    a_core_rst_follows: assert property (
        @(posedge pcie_clk) rst_i |=> core_rst_o
    ) else $error("core reset low after system reset");

endmodule

//--- hdl/switch_debounce.sv
// Debouncer for the buttons and DIP switches, sampled on the slow tick through short shift registers
module switch_debounce #(
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic                      pcie_clk,
    input  logic                      rst_i,
    input  logic                      sample_tick_i,
    input  board_io_pkg::switch_vec_t raw_i,
    output board_io_pkg::switch_vec_t clean_o
);
    import board_io_pkg::*;

    // Sample history per input, newest sample in bit 0
    logic [DEBOUNCE_DEPTH-1:0] hist_q [SWITCH_COUNT];

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            for (int i = 0; i < SWITCH_COUNT; i++) begin
                hist_q[i] <= '0;
            end
            clean_o <= '0;
        end else if (sample_tick_i) begin
            for (int i = 0; i < SWITCH_COUNT; i++) begin
                hist_q[i] <= {hist_q[i][DEBOUNCE_DEPTH-2:0], raw_i[i]};
                // Only a full window of equal samples moves the output
                if (&hist_q[i]) begin
                    clean_o[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    clean_o[i] <= 1'b0;
                end
            end
        end
    end

    // Debounced levels move only on the sample grid
    a_clean_on_tick: assert property (
        @(posedge pcie_clk) disable iff (rst_i)
        !$stable(clean_o) |-> $past(sample_tick_i)
    ) else $error("debounced output changed off the sample tick");

endmodule

//--- hdl/cage_sideband.sv
// QSFP-DD cage sideband, two-flop input synchronizer plus registered I2C drive for the pad buffers
module cage_sideband (
    input  logic                      pcie_clk,
    input  logic                      rst_i,
    input  board_io_pkg::cage_in_t    cage_i,
    input  board_io_pkg::cage_drive_t drive_i,
    output board_io_pkg::cage_in_t    cage_sync_o,
    output board_io_pkg::cage_drive_t drive_o
);
    import board_io_pkg::*;

    // Both lines released, nothing driven low
    localparam cage_drive_t DRIVE_IDLE = '{scl_o: 1'b0, scl_t: 1'b1, sda_o: 1'b0, sda_t: 1'b1};

    cage_in_t sync_meta_q;

    // Inputs come straight from the pins, asynchronous to pcie_clk
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            sync_meta_q <= '1;
            cage_sync_o <= '1;
        end else begin
            sync_meta_q <= cage_i;
            cage_sync_o <= sync_meta_q;
        end
    end

    // Pad enables straight from flops, no logic in front of the buffers
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            drive_o <= DRIVE_IDLE;
        end else begin
            drive_o <= drive_i;
        end
    end

    // One cycle of drive latency once out of reset
    a_drive_delay: assert property (
        @(posedge pcie_clk) disable iff (rst_i)
        !$past(rst_i) |-> (drive_o == $past(drive_i))
    ) else $error("cage drive register out of step with core drive");

endmodule

//--- hdl/board_io_top.sv
// Board I/O top level, joins reset stretcher, switch debouncer and per-cage sideband blocks
module board_io_top #(
    parameter int SAMPLE_DIV     = 4,
    parameter int HOLD_TICKS     = 20,
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic                      pcie_clk,
    input  logic                      rst_i,

    input  logic [1:0]                button_i,
    input  logic [1:0]                sw_i,
    input  board_io_pkg::cage_in_t    cage_i [board_io_pkg::CAGE_COUNT],
    input  board_io_pkg::cage_drive_t drive_i [board_io_pkg::CAGE_COUNT],

    output logic [1:0]                button_o,
    output logic [1:0]                sw_o,
    output board_io_pkg::cage_in_t    cage_sync_o [board_io_pkg::CAGE_COUNT],
    output board_io_pkg::cage_drive_t drive_o [board_io_pkg::CAGE_COUNT],
    output logic                      core_rst_o
);
    import board_io_pkg::*;

    logic        sample_tick;
    switch_vec_t switch_raw;
    switch_vec_t switch_clean;

    // Buttons in the upper bits, switches below
    assign switch_raw = {button_i, sw_i};
    assign button_o   = switch_clean[3:2];
    assign sw_o       = switch_clean[1:0];

    sample_timer #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) sample_timer_inst (
        .pcie_clk     (pcie_clk),
        .rst_i        (rst_i),
        .sample_tick_o(sample_tick)
    );

    rst_release_seq #(
        .HOLD_TICKS(HOLD_TICKS)
    ) rst_release_seq_inst (
        .pcie_clk     (pcie_clk),
        .rst_i        (rst_i),
        .sample_tick_i(sample_tick),
        .core_rst_o   (core_rst_o)
    );

    // Debouncer sits in the stretched core reset
    switch_debounce #(
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) switch_debounce_inst (
        .pcie_clk     (pcie_clk),
        .rst_i        (core_rst_o),
        .sample_tick_i(sample_tick),
        .raw_i        (switch_raw),
        .clean_o      (switch_clean)
    );

    for (genvar c = 0; c < CAGE_COUNT; c++) begin : g_cage
        cage_sideband cage_sideband_inst (
            .pcie_clk   (pcie_clk),
            .rst_i      (rst_i),
            .cage_i     (cage_i[c]),
            .drive_i    (drive_i[c]),
            .cage_sync_o(cage_sync_o[c]),
            .drive_o    (drive_o[c])
        );
    end

endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and power-on reset source, instanced by the board I/O testbench
module tb_clock_gen #(
    parameter int CLK_PERIOD   = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic pcie_clk,
    output logic rst_o
);

    initial begin
        pcie_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;
    end

    // Reset released on a falling edge, like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(negedge pcie_clk);
        rst_o = 1'b0;
    end

endmodule

//--- verif/board_io_tb.sv
// Table-driven testbench for the board I/O top level, run as the simulation top module
module board_io_tb;
    import board_io_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 3;
    localparam int SAMPLE_DIV     = 4;
    localparam int HOLD_TICKS     = 20;
    localparam int DEBOUNCE_DEPTH = 4;
    localparam int REL_MIN        = (HOLD_TICKS - 1) * SAMPLE_DIV + 1;
    localparam int REL_MAX        = HOLD_TICKS * SAMPLE_DIV + 1;
    localparam int RESET_WINDOW   = RESET_CYCLES + REL_MAX;
    localparam int FOLLOW_CYCLES  = (DEBOUNCE_DEPTH + 1) * SAMPLE_DIV;
    localparam int BOUNCE_LEN     = 40;
    localparam int CAGE_CHECKS    = 16;
    localparam int ROWS           = 8;

    typedef struct packed {
        logic        bounce;
        switch_vec_t raw;
        switch_vec_t mask;
        logic [7:0]  wait_cycles;
        switch_vec_t exp_clean;
    } sw_row_t;

    // Columns: bounce, raw {button_i, sw_i}, bounce mask, cycles, expected {button_o, sw_o}
    localparam sw_row_t SW_TABLE [ROWS] = '{
        '{1'b0, 4'b0001, 4'b0000, 8'(FOLLOW_CYCLES), 4'b0001},
        '{1'b0, 4'b0011, 4'b0000, 8'(FOLLOW_CYCLES), 4'b0011},
        '{1'b0, 4'b0111, 4'b0000, 8'(FOLLOW_CYCLES), 4'b0111},
        '{1'b0, 4'b1111, 4'b0000, 8'(FOLLOW_CYCLES), 4'b1111},
        '{1'b1, 4'b1111, 4'b0010, 8'(BOUNCE_LEN + FOLLOW_CYCLES), 4'b1111},
        '{1'b0, 4'b0000, 4'b0000, 8'(FOLLOW_CYCLES), 4'b0000},
        '{1'b1, 4'b0000, 4'b1000, 8'(BOUNCE_LEN + FOLLOW_CYCLES), 4'b0000},
        '{1'b1, 4'b0000, 4'b0101, 8'(BOUNCE_LEN + FOLLOW_CYCLES), 4'b0000}
    };

    logic        pcie_clk;
    logic        rst_i;
    logic [1:0]  button_i;
    logic [1:0]  sw_i;
    cage_in_t    cage_i [CAGE_COUNT];
    cage_drive_t drive_i [CAGE_COUNT];
    logic [1:0]  button_o;
    logic [1:0]  sw_o;
    cage_in_t    cage_sync_o [CAGE_COUNT];
    cage_drive_t drive_o [CAGE_COUNT];
    logic        core_rst_o;

    integer seed;
    int     cycle_count  = 0;
    int     error_count  = 0;
    int     test_errors  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    tb_clock_gen #(
        .CLK_PERIOD  (CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_inst (
        .pcie_clk(pcie_clk),
        .rst_o   (rst_i)
    );

    board_io_top #(
        .SAMPLE_DIV    (SAMPLE_DIV),
        .HOLD_TICKS    (HOLD_TICKS),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) board_io_top_inst (
        .pcie_clk   (pcie_clk),
        .rst_i      (rst_i),
        .button_i   (button_i),
        .sw_i       (sw_i),
        .cage_i     (cage_i),
        .drive_i    (drive_i),
        .button_o   (button_o),
        .sw_o       (sw_o),
        .cage_sync_o(cage_sync_o),
        .drive_o    (drive_o),
        .core_rst_o (core_rst_o)
    );

    function automatic int table_wait_sum();
        int sum;
        sum = 0;
        for (int r = 0; r < ROWS; r++) begin
            sum += SW_TABLE[r].wait_cycles;
        end
        return sum;
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] expected);
        assert (got === expected) else begin
            $display("mismatch at time %0t: %s expected %0h got %0h", $time, name, expected, got);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at time %0t: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Wait for the debounced outputs to reach the new level
    task automatic apply_level_row(input sw_row_t row);
        int waited;
        waited = 0;
        {button_i, sw_i} = row.raw;
        do begin
            @(negedge pcie_clk);
            waited++;
        end while ({button_o, sw_o} !== row.exp_clean && waited < row.wait_cycles);
        compare_value("{button_o,sw_o}", {button_o, sw_o}, row.exp_clean);
    endtask

    task automatic apply_bounce_row(input sw_row_t row);
        logic        bounce;
        int          hold_left;
        logic [31:0] rnd;
        bounce    = 1'b0;
        hold_left = 0;
        for (int j = 0; j < row.wait_cycles; j++) begin
            // Quiet slot of 4 cycles every 16 so no four tick samples all see the bounced level
            if (j >= BOUNCE_LEN || (j % 16) < 4) begin
                bounce = 1'b0;
            end else begin
                if (hold_left == 0) begin
                    rnd       = $random(seed);
                    bounce    = ~bounce;
                    hold_left = 1 + int'(rnd % 3);
                end
                hold_left--;
            end
            {button_i, sw_i} = row.raw ^ (row.mask & {SWITCH_COUNT{bounce}});
            @(negedge pcie_clk);
            compare_value("{button_o,sw_o}", {button_o, sw_o}, row.exp_clean);
        end
    endtask

    // Sync path has 2 cycles of latency, drive register 1
    task automatic run_cage_test();
        cage_in_t    sent_cage [CAGE_COUNT][CAGE_CHECKS];
        cage_drive_t sent_drive [CAGE_COUNT][CAGE_CHECKS];
        logic [31:0] rnd;
        for (int j = 0; j < CAGE_CHECKS + 2; j++) begin
            for (int c = 0; c < CAGE_COUNT; c++) begin
                if (j >= 2) begin
                    compare_value($sformatf("cage_sync_o[%0d]", c), cage_sync_o[c],
                                  sent_cage[c][j-2]);
                end
                if (j >= 1 && j <= CAGE_CHECKS) begin
                    compare_value($sformatf("drive_o[%0d]", c), drive_o[c], sent_drive[c][j-1]);
                end
                if (j < CAGE_CHECKS) begin
                    rnd              = $random(seed);
                    sent_cage[c][j]  = rnd[3:0];
                    sent_drive[c][j] = rnd[7:4];
                    cage_i[c]        = sent_cage[c][j];
                    drive_i[c]       = sent_drive[c][j];
                end
            end
            @(negedge pcie_clk);
        end
    endtask

    always @(posedge pcie_clk) begin
        cycle_count++;
        if (cycle_count > 2 * table_wait_sum() + RESET_WINDOW) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int released_after;
        seed     = 54482;
        button_i = '0;
        sw_i     = '0;
        for (int c = 0; c < CAGE_COUNT; c++) begin
            cage_i[c]  = '1;
            drive_i[c] = '0;
        end

        @(negedge pcie_clk);
        compare_value("core_rst_o", core_rst_o, 1'b1);
        @(negedge rst_i);
        compare_value("core_rst_o", core_rst_o, 1'b1);
        compare_value("{button_o,sw_o}", {button_o, sw_o}, 4'b0000);
        for (int c = 0; c < CAGE_COUNT; c++) begin
            compare_value($sformatf("drive_o[%0d].scl_t", c), drive_o[c].scl_t, 1'b1);
            compare_value($sformatf("drive_o[%0d].sda_t", c), drive_o[c].sda_t, 1'b1);
        end
        finish_test("reset state");

        released_after = 0;
        while (core_rst_o && released_after <= REL_MAX) begin
            @(negedge pcie_clk);
            released_after++;
        end
        assert (!core_rst_o && released_after >= REL_MIN) else begin
            report_failure($sformatf("core reset fall seen after %0d cycles, allowed %0d to %0d",
                                     released_after, REL_MIN, REL_MAX));
        end
        finish_test("reset release");

        for (int r = 0; r < ROWS; r++) begin
            if (SW_TABLE[r].bounce) begin
                apply_bounce_row(SW_TABLE[r]);
            end else begin
                apply_level_row(SW_TABLE[r]);
            end
            finish_test($sformatf("switch row %0d", r));
        end

        run_cage_test();
        finish_test("cage sideband");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- board_io.f
hdl/board_io_pkg.sv
hdl/sample_timer.sv
hdl/rst_release_seq.sv
hdl/switch_debounce.sv
hdl/cage_sideband.sv
hdl/board_io_top.sv
verif/tb_clock_gen.sv
verif/board_io_tb.sv

//--- Bender.yml
package:
  name: board_io

sources:
  - files:
      - hdl/board_io_pkg.sv
      - hdl/sample_timer.sv
      - hdl/rst_release_seq.sv
      - hdl/switch_debounce.sv
      - hdl/cage_sideband.sv
      - hdl/board_io_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/board_io_tb.sv
